/* files.f */
+incdir+design
design/eth_pkg.sv
design/eth_stream_if.sv
design/eth_frame_fifo.sv
design/eth_tx_encoder.sv
design/eth_rx_decoder.sv
design/eth_ctrl_regs.sv
design/eth_mac_subsys.sv
tb/eth_scoreboard.sv
tb/tb_eth_mac_subsys.sv

/* run.sh */
#!/bin/sh
# Build the MAC subsystem testbench with Verilator, run it and scan the log.
cd "$(dirname "$0")" &&
verilator --binary --timing -j 0 --top-module tb_eth_mac_subsys -f files.f -o sim_eth_mac &&
{ ./obj_dir/sim_eth_mac > sim.log 2>&1 || echo "Test failed" >> sim.log; } &&
cat sim.log &&
! grep -q "Test failed" sim.log

/* tb/tb_eth_mac_subsys.sv */
// Testbench for the Ethernet MAC subsystem with a serdes loopback and header fault injection.
`timescale 1ns/10ps
`include "eth_cfg.svh"

module tb_eth_mac_subsys;

    import eth_pkg::*;

    localparam int NUM_FRAMES = 200;
    localparam int MAX_CYCLES = NUM_FRAMES * 64 + 2000;

    logic                   logic_clk;
    logic                   logic_rst;
    logic [`ETH_DATA_W-1:0] s_tx_tdata;
    logic [`ETH_KEEP_W-1:0] s_tx_tkeep;
    logic                   s_tx_tvalid;
    logic                   s_tx_tready;
    logic                   s_tx_tlast;
    logic                   s_tx_tuser;
    logic [`ETH_DATA_W-1:0] m_rx_tdata;
    logic [`ETH_KEEP_W-1:0] m_rx_tkeep;
    logic                   m_rx_tvalid;
    logic                   m_rx_tready;
    logic                   m_rx_tlast;
    logic                   m_rx_tuser;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [7:0]             paddr;
    logic [31:0]            pwdata;
    logic [31:0]            prdata;
    logic                   pready;
    logic                   pslverr;
    logic [`ETH_DATA_W-1:0] serdes_tx_data;
    logic [1:0]             serdes_tx_hdr;
    logic [`ETH_DATA_W-1:0] serdes_rx_data;
    logic [1:0]             serdes_rx_hdr;
    logic                   fault;      // Header forced bad this cycle.
    logic                   end_check;
    int                     pending;    // Good frames not yet delivered or dropped.
    int                     checks;
    int                     errors;
    int                     cycles;
    logic                   inj_armed;
    int                     inj_pos;
    int                     data_idx;
    eth_line_word_u         tx_line;

    assign tx_line = serdes_tx_data;

    eth_mac_subsys eth_mac_subsys_inst (.*);

    eth_scoreboard scoreboard (.*);

    task automatic apb_access(input logic write, input logic [7:0] addr, input logic [31:0] data);
        @(negedge logic_clk);
        psel    = 1'b1;
        pwrite  = write;
        paddr   = addr;
        pwdata  = data;
        penable = 1'b0;
        @(negedge logic_clk);
        penable = 1'b1;
        @(posedge logic_clk);
        while (!pready) @(posedge logic_clk);
        @(negedge logic_clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic send_random_frame();
        int   len;
        int   nbytes;
        logic bad;
        len    = 1 + $urandom % `ETH_MAX_FRAME_WORDS;
        nbytes = 1 + $urandom % `ETH_KEEP_W;
        bad    = ($urandom % 10) == 0;  // About one frame in ten marked bad.
        for (int i = 0; i < len; i++) begin
            @(negedge logic_clk);
            s_tx_tvalid = 1'b1;
            s_tx_tdata  = $urandom;
            s_tx_tlast  = i == len - 1;
            s_tx_tkeep  = s_tx_tlast ? `ETH_KEEP_W'((1 << nbytes) - 1) : '1;
            s_tx_tuser  = bad && s_tx_tlast;
            @(posedge logic_clk);
            while (!s_tx_tready) @(posedge logic_clk);
        end
        @(negedge logic_clk);
        s_tx_tvalid = 1'b0;
        s_tx_tlast  = 1'b0;
        s_tx_tuser  = 1'b0;
    endtask

    task automatic drain();
        while (pending != 0) @(negedge logic_clk);
        repeat (10) @(negedge logic_clk);  // Let the event counters settle.
    endtask

    task automatic set_random_ifg();
        drain();
        apb_access(1'b1, REG_IFG, $urandom % 10);
        apb_access(1'b0, REG_IFG, '0);
    endtask

    initial begin
        logic_clk = 1'b0;
        forever #2 logic_clk = ~logic_clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Serdes loopback and receive back-pressure
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        m_rx_tready    = 1'b0;
        serdes_rx_data = '0;
        serdes_rx_hdr  = HDR_CTRL;
        fault          = 1'b0;
        inj_armed      = 1'b0;
        inj_pos        = 0;
        data_idx       = 0;
        forever begin
            @(negedge logic_clk);
            m_rx_tready = ($urandom % 4) != 0;  // Ready three cycles in four.
            fault       = 1'b0;
            if (serdes_tx_hdr == HDR_CTRL && tx_line.ctrl.ctype == CTRL_START) begin
                inj_armed = ($urandom % 8) == 0;
                inj_pos   = $urandom % 4;  // No fault if the frame is shorter.
                data_idx  = 0;
            end else if (serdes_tx_hdr == HDR_DATA) begin
                fault     = inj_armed && data_idx == inj_pos;
                inj_armed = inj_armed && !fault;
                data_idx++;
            end
            serdes_rx_data = serdes_tx_data;
            serdes_rx_hdr  = fault ? 2'b00 : serdes_tx_hdr;
        end
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge logic_clk);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("Test failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h56f5_ccad));
        logic_rst   = 1'b1;
        s_tx_tdata  = '0;
        s_tx_tkeep  = '0;
        s_tx_tvalid = 1'b0;
        s_tx_tlast  = 1'b0;
        s_tx_tuser  = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        end_check   = 1'b0;
        repeat (5) @(posedge logic_clk);
        @(negedge logic_clk);
        logic_rst = 1'b0;

        apb_access(1'b0, REG_CTRL, '0);  // Reset values.
        apb_access(1'b0, REG_IFG, '0);
        apb_access(1'b0, 8'h1c, '0);
        apb_access(1'b1, 8'h42, 32'h5);
        set_random_ifg();

        for (int n = 0; n < NUM_FRAMES; n++) begin
            if (n == 50 || n == 150) set_random_ifg();
            if (n == 100) begin
                drain();
                apb_access(1'b1, REG_CTRL, 32'h2);  // Transmit off, receive on.
                apb_access(1'b0, REG_CTRL, '0);
            end
            if (n == 103) begin
                repeat (60) @(negedge logic_clk);
                apb_access(1'b1, REG_CTRL, 32'h3);
                apb_access(1'b0, REG_CTRL, '0);
            end
            while (pending >= 2 && (n < 100 || n >= 103)) @(negedge logic_clk);
            send_random_frame();
        end

        drain();
        for (int a = 8; a <= 24; a += 4) apb_access(1'b0, 8'(a), '0);
        apb_access(1'b1, REG_TX_GOOD, '0);
        apb_access(1'b0, REG_TX_GOOD, '0);
        @(negedge logic_clk);
        end_check = 1'b1;
        @(negedge logic_clk);
        end_check = 1'b0;
        @(negedge logic_clk);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* tb/eth_scoreboard.sv */
// Scoreboard that models the MAC subsystem from its host, line and APB traffic and compares.
`timescale 1ns/10ps
`include "eth_cfg.svh"

module eth_scoreboard (
    input  logic                   logic_clk,
    input  logic                   logic_rst,
    input  logic [`ETH_DATA_W-1:0] s_tx_tdata,
    input  logic [`ETH_KEEP_W-1:0] s_tx_tkeep,
    input  logic                   s_tx_tvalid,
    input  logic                   s_tx_tready,
    input  logic                   s_tx_tlast,
    input  logic                   s_tx_tuser,
    input  logic [`ETH_DATA_W-1:0] m_rx_tdata,
    input  logic [`ETH_KEEP_W-1:0] m_rx_tkeep,
    input  logic                   m_rx_tvalid,
    input  logic                   m_rx_tready,
    input  logic                   m_rx_tlast,
    input  logic                   m_rx_tuser,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [7:0]             paddr,
    input  logic [31:0]            pwdata,
    input  logic [31:0]            prdata,
    input  logic                   pready,
    input  logic                   pslverr,
    input  logic [`ETH_DATA_W-1:0] serdes_tx_data,
    input  logic [1:0]             serdes_tx_hdr,
    input  logic                   fault,
    input  logic                   end_check,
    output int                     pending,
    output int                     checks,
    output int                     errors
);

    import eth_pkg::*;

    localparam int BEAT_W = `ETH_DATA_W + `ETH_KEEP_W + 1;

    logic [BEAT_W-1:0] cur_q [$];  // Host frame being captured.
    logic [BEAT_W-1:0] tx_q [$];   // Good frames not yet on the line.
    logic [BEAT_W-1:0] rx_q [$];   // Beats expected on m_rx.
    logic [BEAT_W-1:0] beat;
    logic [32:0]       exp_reg;    // Mapped flag and read value.
    logic [1:0]        ctrl_m;
    logic [7:0]        ifg_m;
    int                cnt_m [5];  // TX_GOOD, TX_BAD, RX_GOOD, RX_BAD, RX_BAD_BLOCK.
    int                good_in;
    int                done_out;
    int                idle_run;   // IDLE blocks since the last other block.
    bit                hit;        // Current line frame had a fault.
    bit                after_rst;
    eth_line_word_u    tx_line;

    assign tx_line = serdes_tx_data;
    assign pending = good_in - done_out;

    task automatic verify(input bit ok, input string msg);
        checks++;
        if (!ok) begin
            errors++;
            $display("FAILED at %0t: %s", $time, msg);
        end
    endtask

    function automatic int count_bytes(input logic [`ETH_KEEP_W-1:0] keep);
        int n;
        n = 0;
        for (int i = 0; i < `ETH_KEEP_W; i++) n += int'(keep[i]);
        return n;
    endfunction

    function automatic logic [32:0] reg_model(input logic [7:0] addr);
        case (addr)
            REG_CTRL:         return {1'b1, 30'd0, ctrl_m};
            REG_IFG:          return {1'b1, 24'd0, ifg_m};
            REG_TX_GOOD:      return {1'b1, 32'(cnt_m[0])};
            REG_TX_BAD:       return {1'b1, 32'(cnt_m[1])};
            REG_RX_GOOD:      return {1'b1, 32'(cnt_m[2])};
            REG_RX_BAD:       return {1'b1, 32'(cnt_m[3])};
            REG_RX_BAD_BLOCK: return {1'b1, 32'(cnt_m[4])};
            default:          return '0;
        endcase
    endfunction

    always @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            cur_q.delete();
            tx_q.delete();
            rx_q.delete();
            ctrl_m    = `ETH_CTRL_RESET;
            ifg_m     = 8'(`ETH_IFG_RESET);
            good_in   = 0;
            done_out  = 0;
            idle_run  = 0;
            hit       = 1'b0;
            after_rst = 1'b1;
            checks    = 0;
            errors    = 0;
            for (int i = 0; i < 5; i++) cnt_m[i] = 0;
        end else begin
            if (after_rst) begin
                verify(!m_rx_tvalid && !pslverr && serdes_tx_hdr == HDR_CTRL &&
                       tx_line.ctrl.ctype == CTRL_IDLE, "outputs not idle after reset");
                after_rst = 1'b0;
            end

            // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
            // Frames entering the model from the host
            // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
            if (s_tx_tvalid && s_tx_tready) begin
                cur_q.push_back({s_tx_tlast, s_tx_tkeep, s_tx_tdata});
                if (s_tx_tlast && s_tx_tuser) begin
                    cnt_m[1]++;  // Dropped by the TX FIFO.
                end else if (s_tx_tlast) begin
                    cnt_m[0]++;
                    good_in++;
                    foreach (cur_q[i]) tx_q.push_back(cur_q[i]);
                end
                if (s_tx_tlast) cur_q.delete();
            end

            // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
            // Line side
            // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
            if (fault) begin
                hit = 1'b1;
                cnt_m[4]++;
            end
            if (serdes_tx_hdr == HDR_DATA) begin
                idle_run = 0;
            end else if (tx_line.ctrl.ctype == CTRL_IDLE) begin
                idle_run++;
            end else if (tx_line.ctrl.ctype == CTRL_START) begin
                verify(ctrl_m[0], "START sent while transmit is disabled");
                verify(idle_run >= int'(ifg_m),
                       $sformatf("START after %0d IDLE blocks, gap is %0d", idle_run, ifg_m));
                idle_run = 0;
                hit      = 1'b0;
            end else if (tx_line.ctrl.ctype == CTRL_TERM) begin
                idle_run = 0;
                if (tx_q.size() == 0) begin
                    verify(1'b0, "TERM on the line with no frame sent");
                end else begin
                    beat = '0;
                    while (tx_q.size() != 0 && !beat[BEAT_W-1]) begin
                        beat = tx_q.pop_front();
                        if (!hit) rx_q.push_back(beat);
                    end
                    verify(int'(tx_line.ctrl.last_bytes) ==
                           count_bytes(beat[`ETH_DATA_W +: `ETH_KEEP_W]),
                           $sformatf("TERM last_bytes %0d for keep %b", tx_line.ctrl.last_bytes,
                           beat[`ETH_DATA_W +: `ETH_KEEP_W]));
                    if (hit) begin
                        cnt_m[3]++;  // Closed bad and dropped by the RX FIFO.
                        done_out++;
                    end else begin
                        cnt_m[2]++;
                    end
                end
            end

            // Receive stream.
            if (m_rx_tvalid && m_rx_tready) begin
                if (rx_q.size() == 0) begin
                    verify(1'b0, "unexpected beat on the receive stream");
                end else begin
                    beat = rx_q.pop_front();
                    verify({m_rx_tlast, m_rx_tkeep, m_rx_tdata} == beat && !m_rx_tuser,
                           $sformatf("m_rx beat %h user %b, expected %h",
                           {m_rx_tlast, m_rx_tkeep, m_rx_tdata}, m_rx_tuser, beat));
                    if (beat[BEAT_W-1]) done_out++;
                end
            end

            // APB access phase.
            if (psel && penable) begin
                exp_reg = reg_model(paddr);
                verify(pready, "pready low in the access phase");
                verify(pslverr == !exp_reg[32], $sformatf("pslverr %b at address %h",
                       pslverr, paddr));
                if (!pwrite && exp_reg[32])
                    verify(prdata == exp_reg[31:0], $sformatf("register %h read %h, expected %h",
                           paddr, prdata, exp_reg[31:0]));
                if (pwrite && paddr == REG_CTRL) ctrl_m = pwdata[1:0];
                if (pwrite && paddr == REG_IFG) ifg_m = pwdata[7:0];
                if (pwrite && exp_reg[32] && paddr >= REG_TX_GOOD)
                    cnt_m[(int'(paddr) - 8) / 4] = 0;
            end

            if (end_check)
                verify(cur_q.size() == 0 && tx_q.size() == 0 && rx_q.size() == 0,
                       "frames still in flight at the end of the run");
        end
    end

endmodule

/* design/eth_mac_subsys.sv */
// Ethernet MAC subsystem top: register block, TX and RX frame FIFOs, encoder and decoder.
`timescale 1ns/10ps
`include "eth_cfg.svh"

module eth_mac_subsys (
    input  logic                   logic_clk,
    input  logic                   logic_rst,
    input  logic [`ETH_DATA_W-1:0] s_tx_tdata,
    input  logic [`ETH_KEEP_W-1:0] s_tx_tkeep,
    input  logic                   s_tx_tvalid,
    output logic                   s_tx_tready,
    input  logic                   s_tx_tlast,
    input  logic                   s_tx_tuser,
    output logic [`ETH_DATA_W-1:0] m_rx_tdata,
    output logic [`ETH_KEEP_W-1:0] m_rx_tkeep,
    output logic                   m_rx_tvalid,
    input  logic                   m_rx_tready,
    output logic                   m_rx_tlast,
    output logic                   m_rx_tuser,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [7:0]             paddr,
    input  logic [31:0]            pwdata,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,
    output logic [`ETH_DATA_W-1:0] serdes_tx_data,
    output logic [1:0]             serdes_tx_hdr,
    input  logic [`ETH_DATA_W-1:0] serdes_rx_data,
    input  logic [1:0]             serdes_rx_hdr
);

    eth_stream_if tx_in_if ();
    eth_stream_if tx_fifo_out ();
    eth_stream_if rx_dec_out ();
    eth_stream_if rx_out_if ();

    logic       tx_good, tx_bad, tx_overflow;
    logic       rx_good, rx_bad, rx_overflow, rx_bad_block;
    logic       tx_enable, rx_enable;
    logic [7:0] ifg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Host stream ports
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign tx_in_if.tdata  = s_tx_tdata;
    assign tx_in_if.tkeep  = s_tx_tkeep;
    assign tx_in_if.tvalid = s_tx_tvalid;
    assign tx_in_if.tlast  = s_tx_tlast;
    assign tx_in_if.tuser  = s_tx_tuser;
    assign s_tx_tready     = tx_in_if.tready;

    assign m_rx_tdata       = rx_out_if.tdata;
    assign m_rx_tkeep       = rx_out_if.tkeep;
    assign m_rx_tvalid      = rx_out_if.tvalid;
    assign m_rx_tlast       = rx_out_if.tlast;
    assign m_rx_tuser       = rx_out_if.tuser;
    assign rx_out_if.tready = m_rx_tready;

    eth_ctrl_regs ctrl_regs (
        .logic_clk, .logic_rst,
        .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
        .tx_good, .tx_bad, .tx_overflow,
        .rx_good, .rx_bad, .rx_overflow, .rx_bad_block,
        .tx_enable, .rx_enable, .ifg
    );

    eth_frame_fifo #(.DEPTH(`ETH_FIFO_DEPTH)) tx_fifo (
        .logic_clk, .logic_rst,
        .in(tx_in_if), .out(tx_fifo_out),
        .good_frame(tx_good), .bad_frame(tx_bad), .overflow(tx_overflow)
    );

    eth_tx_encoder tx_encoder (
        .logic_clk, .logic_rst,
        .in(tx_fifo_out), .tx_enable, .ifg,
        .serdes_tx_data, .serdes_tx_hdr
    );

    eth_rx_decoder rx_decoder (
        .logic_clk, .logic_rst,
        .serdes_rx_data, .serdes_rx_hdr, .rx_enable,
        .out(rx_dec_out), .bad_block(rx_bad_block)
    );

    eth_frame_fifo #(.DEPTH(`ETH_FIFO_DEPTH)) rx_fifo (
        .logic_clk, .logic_rst,
        .in(rx_dec_out), .out(rx_out_if),
        .good_frame(rx_good), .bad_frame(rx_bad), .overflow(rx_overflow)
    );

endmodule

/* design/eth_ctrl_regs.sv */
// APB register block with the MAC configuration and saturating event counters.
`timescale 1ns/10ps
`include "eth_cfg.svh"

module eth_ctrl_regs (
    input  logic        logic_clk,
    input  logic        logic_rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    input  logic        tx_good,
    input  logic        tx_bad,
    input  logic        tx_overflow,
    input  logic        rx_good,
    input  logic        rx_bad,
    input  logic        rx_overflow,
    input  logic        rx_bad_block,
    output logic        tx_enable,
    output logic        rx_enable,
    output logic [7:0]  ifg
);

    import eth_pkg::*;

    localparam int CNT_W = 16;
    localparam int N_CNT = 5;

    logic [CNT_W-1:0] cnt [N_CNT];
    logic [N_CNT-1:0] evt;
    logic [2:0]       cnt_idx;
    logic             cnt_sel;
    logic             mapped;
    logic             wr_en;

    // Counter order follows the register map from TX_GOOD up.
    assign evt     = {rx_bad_block, rx_bad | rx_overflow, rx_good, tx_bad | tx_overflow, tx_good};
    assign cnt_idx = 3'((paddr - REG_TX_GOOD) >> 2);
    assign wr_en   = psel && penable && pwrite;
    assign pready  = 1'b1;  // Zero wait states.
    assign pslverr = psel && penable && !mapped;

    always_comb begin
        mapped  = 1'b1;
        cnt_sel = 1'b0;
        prdata  = '0;
        case (paddr)
            REG_CTRL: prdata = {30'd0, rx_enable, tx_enable};
            REG_IFG:  prdata = {24'd0, ifg};
            REG_TX_GOOD, REG_TX_BAD, REG_RX_GOOD, REG_RX_BAD, REG_RX_BAD_BLOCK: begin
                cnt_sel = 1'b1;
                prdata  = {16'd0, cnt[cnt_idx]};
            end
            default: mapped = 1'b0;
        endcase
    end

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            {rx_enable, tx_enable} <= `ETH_CTRL_RESET;
            ifg                    <= 8'(`ETH_IFG_RESET);
            for (int i = 0; i < N_CNT; i++) cnt[i] <= '0;
        end else begin
            if (wr_en && paddr == REG_CTRL) {rx_enable, tx_enable} <= pwdata[1:0];
            if (wr_en && paddr == REG_IFG) ifg <= pwdata[7:0];
            for (int i = 0; i < N_CNT; i++) begin
                if (wr_en && cnt_sel && cnt_idx == 3'(i)) begin
                    cnt[i] <= CNT_W'(evt[i]);  // Clear, keeping a same-cycle event.
                end else if (evt[i] && cnt[i] != '1) begin
                    cnt[i] <= cnt[i] + 1'b1;
                end
            end
        end
    end

endmodule

/* design/eth_rx_decoder.sv */
// Receive decoder that rebuilds frames from line blocks and flags broken blocks.
`timescale 1ns/10ps
`include "eth_cfg.svh"

module eth_rx_decoder (
    input  logic                   logic_clk,
    input  logic                   logic_rst,
    input  logic [`ETH_DATA_W-1:0] serdes_rx_data,
    input  logic [1:0]             serdes_rx_hdr,
    input  logic                   rx_enable,
    eth_stream_if.src              out,
    output logic                   bad_block
);

    import eth_pkg::*;

    localparam int KEEP_W = `ETH_KEEP_W;

    typedef enum logic {ST_IDLE, ST_FRAME} state_t;

    state_t                 state;
    eth_line_word_u         blk;
    logic                   is_data;
    logic                   is_ctrl;
    logic                   is_start;
    logic                   is_term;
    logic                   blk_err;
    logic                   emit;
    logic [KEEP_W-1:0]      term_keep;
    logic [`ETH_DATA_W-1:0] hold_data;  // Word waiting for the next block.
    logic                   hold_valid;
    logic                   frame_err;

    assign blk      = serdes_rx_data;
    assign is_data  = serdes_rx_hdr == HDR_DATA;
    assign is_ctrl  = serdes_rx_hdr == HDR_CTRL;
    assign is_start = is_ctrl && blk.ctrl.ctype == CTRL_START;
    assign is_term  = is_ctrl && blk.ctrl.ctype == CTRL_TERM;
    assign blk_err  = !is_data && !is_start && !is_term &&
                      !(is_ctrl && blk.ctrl.ctype == CTRL_IDLE);  // Bad header or type.

    // A START in a frame closes the held word as a bad frame.
    assign emit = rx_enable && state == ST_FRAME &&
                  ((is_data && hold_valid) || is_term || is_start);

    assign term_keep = (blk.ctrl.last_bytes >= 8'(KEEP_W)) ? '1 :
                       KEEP_W'((1 << blk.ctrl.last_bytes) - 1);

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            state      <= ST_IDLE;
            hold_valid <= 1'b0;
            frame_err  <= 1'b0;
            out.tvalid <= 1'b0;
            bad_block  <= 1'b0;
        end else begin
            out.tvalid <= emit;
            bad_block  <= rx_enable &&
                          (blk_err || (state == ST_IDLE ? is_data : is_start));
            if (rx_enable && (state == ST_IDLE ? is_start : (is_start || is_term))) begin
                hold_valid <= 1'b0;
                frame_err  <= 1'b0;
                state      <= is_term ? ST_IDLE : ST_FRAME;
            end else if (rx_enable && state == ST_FRAME) begin
                if (is_data) hold_valid <= 1'b1;
                if (blk_err) frame_err <= 1'b1;  // Closed at TERM.
            end
        end
    end

    always_ff @(posedge logic_clk) begin
        if (emit) begin
            out.tdata <= hold_data;
            out.tkeep <= is_term ? term_keep : '1;
            out.tlast <= !is_data;
            out.tuser <= is_start || frame_err || !hold_valid;
        end
        if (rx_enable && is_data) hold_data <= blk.raw;
    end

endmodule

/* design/eth_tx_encoder.sv */
// Transmit encoder that wraps committed frames in START and TERM blocks with an IDLE gap.
`timescale 1ns/10ps
`include "eth_cfg.svh"

module eth_tx_encoder (
    input  logic                   logic_clk,
    input  logic                   logic_rst,
    eth_stream_if.snk              in,
    input  logic                   tx_enable,
    input  logic [7:0]             ifg,
    output logic [`ETH_DATA_W-1:0] serdes_tx_data,
    output logic [1:0]             serdes_tx_hdr
);

    import eth_pkg::*;

    typedef enum logic [1:0] {ST_GAP, ST_START, ST_DATA, ST_TERM} state_t;

    state_t         state;
    logic [7:0]     gap_cnt;     // IDLE blocks sent since the last TERM.
    logic [7:0]     last_bytes;
    eth_line_word_u tx_word;

    assign in.tready      = state == ST_DATA;  // Whole frames only, no stall inside.
    assign serdes_tx_data = tx_word.raw;

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            state         <= ST_GAP;
            gap_cnt       <= '0;
            last_bytes    <= '0;
            serdes_tx_hdr <= HDR_CTRL;
            tx_word.ctrl  <= '{ctype: CTRL_IDLE, last_bytes: 8'd0, rsvd: 16'd0};
        end else begin
            serdes_tx_hdr <= HDR_CTRL;
            tx_word.ctrl  <= '{ctype: CTRL_IDLE, last_bytes: 8'd0, rsvd: 16'd0};
            case (state)
                ST_GAP: begin
                    if (gap_cnt != 8'hff) gap_cnt <= gap_cnt + 1'b1;
                    if (tx_enable && in.tvalid && gap_cnt >= ifg) state <= ST_START;
                end
                ST_START: begin
                    tx_word.ctrl <= '{ctype: CTRL_START, last_bytes: 8'd0, rsvd: 16'd0};
                    state        <= ST_DATA;
                end
                ST_DATA: begin
                    if (in.tvalid) begin
                        serdes_tx_hdr <= HDR_DATA;
                        tx_word.raw   <= in.tdata;
                        if (in.tlast) begin
                            last_bytes <= 8'($countones(in.tkeep));
                            state      <= ST_TERM;
                        end
                    end
                end
                default: begin
                    tx_word.ctrl <= '{ctype: CTRL_TERM, last_bytes: last_bytes, rsvd: 16'd0};
                    gap_cnt      <= '0;
                    state        <= ST_GAP;
                end
            endcase
        end
    end

endmodule

/* design/eth_frame_fifo.sv */
// Store-and-forward frame FIFO that commits good frames and drops bad or overflowing ones.
`timescale 1ns/10ps
`include "eth_cfg.svh"

module eth_frame_fifo #(
    parameter int DEPTH = `ETH_FIFO_DEPTH
) (
    input  logic      logic_clk,
    input  logic      logic_rst,
    eth_stream_if.snk in,
    eth_stream_if.src out,
    output logic      good_frame,
    output logic      bad_frame,
    output logic      overflow
);

    localparam int DATA_W = `ETH_DATA_W;
    localparam int KEEP_W = `ETH_KEEP_W;
    localparam int WORD_W = DATA_W + KEEP_W + 1;
    localparam int PTR_W  = $clog2(DEPTH);
    localparam int LEN_W  = $clog2(`ETH_MAX_FRAME_WORDS + 1);

    logic [WORD_W-1:0] mem [DEPTH];
    logic [PTR_W:0]    wr_ptr;
    logic [PTR_W:0]    commit_ptr;
    logic [PTR_W:0]    rd_ptr;
    logic [LEN_W-1:0]  frame_len;
    logic              drop_frame;
    logic              ovf_frame;
    logic              full;
    logic              too_long;
    logic              beat;
    logic              beat_ok;
    logic              frame_bad;
    logic              load;
    logic              out_valid;
    logic [WORD_W-1:0] out_word;

    assign in.tready = 1'b1;  // Full is handled as a drop.
    assign beat      = in.tvalid && in.tready;
    assign full      = (wr_ptr - rd_ptr) == (PTR_W + 1)'(DEPTH);
    assign too_long  = frame_len == LEN_W'(`ETH_MAX_FRAME_WORDS);
    assign beat_ok   = !drop_frame && !full && !too_long;
    assign frame_bad = !beat_ok || in.tuser;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            wr_ptr     <= '0;
            commit_ptr <= '0;
            frame_len  <= '0;
            drop_frame <= 1'b0;
            ovf_frame  <= 1'b0;
            good_frame <= 1'b0;
            bad_frame  <= 1'b0;
            overflow   <= 1'b0;
        end else begin
            good_frame <= 1'b0;
            bad_frame  <= 1'b0;
            overflow   <= 1'b0;
            if (beat && in.tlast) begin
                frame_len  <= '0;
                drop_frame <= 1'b0;
                ovf_frame  <= 1'b0;
                if (frame_bad) begin
                    wr_ptr    <= commit_ptr;  // Rewind past the dropped words.
                    bad_frame <= 1'b1;
                    overflow  <= ovf_frame || (full && !drop_frame);
                end else begin
                    wr_ptr     <= wr_ptr + 1'b1;
                    commit_ptr <= wr_ptr + 1'b1;
                    good_frame <= 1'b1;
                end
            end else if (beat) begin
                if (!too_long) frame_len <= frame_len + 1'b1;
                if (beat_ok) wr_ptr <= wr_ptr + 1'b1;
                else drop_frame <= 1'b1;
                if (full && !drop_frame) ovf_frame <= 1'b1;
            end
        end
    end

    always_ff @(posedge logic_clk) begin
        if (beat && beat_ok) mem[wr_ptr[PTR_W-1:0]] <= {in.tlast, in.tkeep, in.tdata};
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read side, committed words only
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign load = (rd_ptr != commit_ptr) && (!out_valid || out.tready);

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            rd_ptr    <= '0;
            out_valid <= 1'b0;
        end else if (load) begin
            rd_ptr    <= rd_ptr + 1'b1;
            out_valid <= 1'b1;
        end else if (out.tready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge logic_clk) begin
        if (load) out_word <= mem[rd_ptr[PTR_W-1:0]];
    end

    assign out.tvalid = out_valid;
    assign {out.tlast, out.tkeep, out.tdata} = out_word;
    assign out.tuser  = 1'b0;  // Only good frames leave.

endmodule

/* design/eth_stream_if.sv */
// Frame stream interface with byte enables and a bad-frame flag on the last beat.
`timescale 1ns/10ps
`include "eth_cfg.svh"

interface eth_stream_if;

    logic [`ETH_DATA_W-1:0] tdata;
    logic [`ETH_KEEP_W-1:0] tkeep;
    logic                   tvalid;
    logic                   tready;
    logic                   tlast;
    logic                   tuser;  // Bad frame, valid with tlast.

    modport src (
        output tdata, tkeep, tvalid, tlast, tuser,
        input  tready
    );

    modport snk (
        input  tdata, tkeep, tvalid, tlast, tuser,
        output tready
    );

endinterface

/* design/eth_pkg.sv */
// Ethernet MAC shared types: sync headers, control words, line word and register map.
package eth_pkg;

    typedef enum logic [1:0] {
        HDR_DATA = 2'b01,
        HDR_CTRL = 2'b10
    } eth_hdr_t;

    typedef enum logic [7:0] {
        CTRL_IDLE  = 8'h1e,
        CTRL_START = 8'h78,
        CTRL_TERM  = 8'h87
    } eth_ctrl_type_t;

    typedef struct packed {
        eth_ctrl_type_t ctype;      // Block type.
        logic [7:0]     last_bytes; // Valid bytes in final data word, TERM only.
        logic [15:0]    rsvd;
    } eth_ctrl_word_t;

    // The sync header picks which view is valid.
    typedef union packed {
        logic [31:0]    raw;
        eth_ctrl_word_t ctrl;
    } eth_line_word_u;

    typedef enum logic [7:0] {
        REG_CTRL         = 8'h00,
        REG_IFG          = 8'h04,
        REG_TX_GOOD      = 8'h08,
        REG_TX_BAD       = 8'h0c,
        REG_RX_GOOD      = 8'h10,
        REG_RX_BAD       = 8'h14,
        REG_RX_BAD_BLOCK = 8'h18
    } eth_reg_addr_t;

endpackage

/* design/eth_cfg.svh */
// Ethernet MAC subsystem configuration: widths, FIFO sizing and register reset values.
`ifndef ETH_CFG_SVH
`define ETH_CFG_SVH

// Stream and line word widths.
`define ETH_DATA_W 32
`define ETH_KEEP_W 4

// Frame FIFO sizing.
`define ETH_FIFO_DEPTH 64
`define ETH_MAX_FRAME_WORDS 16

// Register reset values.
`define ETH_IFG_RESET 3
`define ETH_CTRL_RESET 2'b11

`endif
